/* issue_core.f */
logic/ooo_pkg.sv
logic/rename_unit.sv
logic/rs_entry.sv
logic/rs.sv
logic/alu_exec.sv
logic/issue_core.sv
testbench/issue_core_props.sv
testbench/issue_core_checker.sv
testbench/issue_core_tb.sv

/* logic/alu_exec.sv */
`timescale 1ns/1ps

module alu_exec
   import ooo_pkg::*;
(
   input  logic    clk,
   input  logic    reset,

   input  logic    iss_valid,
   input  t_opcode iss_op,
   input  t_tag    iss_tag,
   input  t_imm    iss_imm,
   input  t_data   iss_data1,
   input  t_data   iss_data2,

   output logic    res_valid,
   output t_tag    res_tag,
   output t_data   res_data
);

   always_ff @(posedge clk) begin
      if (reset) begin
         res_valid <= 1'b0;
      end else begin
         res_valid <= iss_valid;
      end
   end

   // Result payload, broadcast one cycle after issue
   always_ff @(posedge clk) begin
      if (iss_valid) begin
         res_tag <= iss_tag;
         unique case (iss_op)
            OP_ADD: res_data <= iss_data1 + iss_data2;
            OP_SUB: res_data <= iss_data1 - iss_data2;
            OP_XOR: res_data <= iss_data1 ^ iss_data2;
            OP_LDI: res_data <= {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, iss_imm};
         endcase
      end
   end

endmodule

/* logic/issue_core.sv */
`timescale 1ns/1ps

module issue_core
   import ooo_pkg::*;
(
   input  logic     clk,
   input  logic     reset,

   input  logic     instr_valid,
   input  t_opcode  instr_op,
   input  t_reg_idx instr_rd,
   input  t_reg_idx instr_rs1,
   input  t_reg_idx instr_rs2,
   input  t_imm     instr_imm,
   output logic     instr_stall,

   output logic     res_valid,
   output t_tag     res_tag,
   output t_data    res_data
);

   // Rename to station
   logic    disp_valid;
   t_opcode disp_op;
   t_tag    disp_tag;
   t_imm    disp_imm;
   logic    src_rdy1;
   t_tag    src_tag1;
   t_data   src_data1;
   logic    src_rdy2;
   t_tag    src_tag2;
   t_data   src_data2;
   logic    rs_stall;

   // Station to ALU
   logic    iss_valid;
   t_opcode iss_op;
   t_tag    iss_tag;
   t_imm    iss_imm;
   t_data   iss_data1;
   t_data   iss_data2;

   rename_unit u_rename (
      .clk         (clk),
      .reset       (reset),
      .instr_valid (instr_valid),
      .instr_op    (instr_op),
      .instr_rd    (instr_rd),
      .instr_rs1   (instr_rs1),
      .instr_rs2   (instr_rs2),
      .instr_imm   (instr_imm),
      .instr_stall (instr_stall),
      .rs_stall    (rs_stall),
      .disp_valid  (disp_valid),
      .disp_op     (disp_op),
      .disp_tag    (disp_tag),
      .disp_imm    (disp_imm),
      .src_rdy1    (src_rdy1),
      .src_tag1    (src_tag1),
      .src_data1   (src_data1),
      .src_rdy2    (src_rdy2),
      .src_tag2    (src_tag2),
      .src_data2   (src_data2),
      .res_valid   (res_valid),
      .res_tag     (res_tag),
      .res_data    (res_data)
   );

   rs #(
      .NUM_RS_ENTS (8)
   ) u_rs (
      .clk        (clk),
      .reset      (reset),
      .disp_valid (disp_valid),
      .disp_op    (disp_op),
      .disp_tag   (disp_tag),
      .disp_imm   (disp_imm),
      .src_rdy1   (src_rdy1),
      .src_tag1   (src_tag1),
      .src_data1  (src_data1),
      .src_rdy2   (src_rdy2),
      .src_tag2   (src_tag2),
      .src_data2  (src_data2),
      .rs_stall   (rs_stall),
      .res_valid  (res_valid),
      .res_tag    (res_tag),
      .res_data   (res_data),
      .iss_valid  (iss_valid),
      .iss_op     (iss_op),
      .iss_tag    (iss_tag),
      .iss_imm    (iss_imm),
      .iss_data1  (iss_data1),
      .iss_data2  (iss_data2)
   );

   alu_exec u_alu (
      .clk       (clk),
      .reset     (reset),
      .iss_valid (iss_valid),
      .iss_op    (iss_op),
      .iss_tag   (iss_tag),
      .iss_imm   (iss_imm),
      .iss_data1 (iss_data1),
      .iss_data2 (iss_data2),
      .res_valid (res_valid),
      .res_tag   (res_tag),
      .res_data  (res_data)
   );

endmodule

/* logic/ooo_pkg.sv */
package ooo_pkg;

   // Architectural state and tag space
   localparam int NUM_ARCH_REGS = 8;
   localparam int NUM_TAGS      = 16;

   // Datapath widths
   localparam int DATA_WIDTH    = 32;
   localparam int IMM_WIDTH     = 16;

   // Architectural register number
   typedef logic [$clog2(NUM_ARCH_REGS)-1:0] t_reg_idx;

   // Result tag, handed out round-robin by rename
   typedef logic [$clog2(NUM_TAGS)-1:0] t_tag;

   // Operand or result value
   typedef logic [DATA_WIDTH-1:0] t_data;

   // Immediate field, zero-extended by the ALU
   typedef logic [IMM_WIDTH-1:0] t_imm;

   // ALU operations
   typedef enum logic [1:0] {
      OP_ADD = 2'b00,
      OP_SUB = 2'b01,
      OP_XOR = 2'b10,
      OP_LDI = 2'b11
   } t_opcode;

endpackage

/* logic/rename_unit.sv */
`timescale 1ns/1ps

module rename_unit
   import ooo_pkg::*;
(
   input  logic     clk,
   input  logic     reset,

   input  logic     instr_valid,
   input  t_opcode  instr_op,
   input  t_reg_idx instr_rd,
   input  t_reg_idx instr_rs1,
   input  t_reg_idx instr_rs2,
   input  t_imm     instr_imm,
   output logic     instr_stall,

   input  logic     rs_stall,
   output logic     disp_valid,
   output t_opcode  disp_op,
   output t_tag     disp_tag,
   output t_imm     disp_imm,
   output logic     src_rdy1,
   output t_tag     src_tag1,
   output t_data    src_data1,
   output logic     src_rdy2,
   output t_tag     src_tag2,
   output t_data    src_data2,

   input  logic     res_valid,
   input  t_tag     res_tag,
   input  t_data    res_data
);

   t_data                    reg_val   [NUM_ARCH_REGS];
   t_tag                     alias_tag [NUM_ARCH_REGS];
   logic [NUM_ARCH_REGS-1:0] pending;
   t_tag                     next_tag;
   logic                     accept;

   logic                     rdy1_in;
   t_tag                     tag1_in;
   t_data                    data1_in;
   logic                     rdy2_in;
   t_tag                     tag2_in;
   t_data                    data2_in;

   // Source lookup through the alias table, with the result bus as bypass
   function automatic void rename_src(input t_reg_idx r, output logic rdy,
                                      output t_tag tag, output t_data data);
      tag = alias_tag[r];
      if (!pending[r]) begin
         rdy  = 1'b1;
         data = reg_val[r];
      end else if (res_valid && res_tag == alias_tag[r]) begin
         rdy  = 1'b1;
         data = res_data;
      end else begin
         rdy  = 1'b0;
         data = '0;
      end
   endfunction

   // Hold the source only while the dispatch register cannot drain
   assign instr_stall = disp_valid & rs_stall;
   assign accept      = instr_valid & ~instr_stall;

   always_comb begin
      rename_src(instr_rs1, rdy1_in, tag1_in, data1_in);
      rename_src(instr_rs2, rdy2_in, tag2_in, data2_in);
   end

   // Register values, pending bits and the tag counter
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            reg_val[i] <= '0;
         end
         pending  <= '0;
         next_tag <= '0;
      end else begin
         if (res_valid) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
               // Only the latest writer retires into the file
               if (pending[i] && alias_tag[i] == res_tag) begin
                  reg_val[i] <= res_data;
                  pending[i] <= 1'b0;
               end
            end
         end
         // New writer wins over a retiring one on the same register
         if (accept) begin
            pending[instr_rd] <= 1'b1;
            next_tag          <= next_tag + t_tag'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         alias_tag[instr_rd] <= next_tag;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         disp_valid <= 1'b0;
      end else if (!instr_stall) begin
         disp_valid <= accept;
      end
   end

   // Dispatch register, snoops the result bus while it waits
   always_ff @(posedge clk) begin
      if (accept) begin
         disp_op   <= instr_op;
         disp_tag  <= next_tag;
         disp_imm  <= instr_imm;
         src_rdy1  <= rdy1_in;
         src_tag1  <= tag1_in;
         src_data1 <= data1_in;
         src_rdy2  <= rdy2_in;
         src_tag2  <= tag2_in;
         src_data2 <= data2_in;
      end else begin
         if (res_valid && !src_rdy1 && src_tag1 == res_tag) begin
            src_rdy1  <= 1'b1;
            src_data1 <= res_data;
         end
         if (res_valid && !src_rdy2 && src_tag2 == res_tag) begin
            src_rdy2  <= 1'b1;
            src_data2 <= res_data;
         end
      end
   end

endmodule

/* logic/rs.sv */
`timescale 1ns/1ps

module rs
   import ooo_pkg::*;
#(
   parameter int NUM_RS_ENTS = 8
) (
   input  logic    clk,
   input  logic    reset,

   input  logic    disp_valid,
   input  t_opcode disp_op,
   input  t_tag    disp_tag,
   input  t_imm    disp_imm,
   input  logic    src_rdy1,
   input  t_tag    src_tag1,
   input  t_data   src_data1,
   input  logic    src_rdy2,
   input  t_tag    src_tag2,
   input  t_data   src_data2,
   output logic    rs_stall,

   input  logic    res_valid,
   input  t_tag    res_tag,
   input  t_data   res_data,

   output logic    iss_valid,
   output t_opcode iss_op,
   output t_tag    iss_tag,
   output t_imm    iss_imm,
   output t_data   iss_data1,
   output t_data   iss_data2
);

   logic [NUM_RS_ENTS-1:0]           ent_valid;
   logic [NUM_RS_ENTS-1:0]           ent_req;
   logic [NUM_RS_ENTS-1:0]           ent_alloc;
   logic [NUM_RS_ENTS-1:0]           ent_grant;
   t_opcode                          ent_op    [NUM_RS_ENTS];
   t_tag                             ent_tag   [NUM_RS_ENTS];
   t_imm                             ent_imm   [NUM_RS_ENTS];
   t_data                            ent_data1 [NUM_RS_ENTS];
   t_data                            ent_data2 [NUM_RS_ENTS];
   logic                             alloc;
   logic [$clog2(NUM_RS_ENTS+1)-1:0] free_cnt;

   // Isolate the lowest set bit
   function automatic logic [NUM_RS_ENTS-1:0] lowest_one(input logic [NUM_RS_ENTS-1:0] v);
      return v & (~v + 1'b1);
   endfunction

   always_comb begin
      free_cnt = '0;
      for (int i = 0; i < NUM_RS_ENTS; i++) begin
         if (!ent_valid[i]) begin
            free_cnt = free_cnt + 1'b1;
         end
      end
   end

   // Stall keeps one spare entry for the dispatch register
   assign rs_stall  = free_cnt < 2;
   assign alloc     = disp_valid & ~rs_stall;
   assign ent_alloc = alloc ? lowest_one(~ent_valid) : '0;

   // Lowest ready entry wins
   assign iss_valid = |ent_req;
   assign ent_grant = lowest_one(ent_req);

   always_comb begin
      iss_op    = OP_ADD;
      iss_tag   = '0;
      iss_imm   = '0;
      iss_data1 = '0;
      iss_data2 = '0;
      for (int i = 0; i < NUM_RS_ENTS; i++) begin
         if (ent_grant[i]) begin
            iss_op    = ent_op[i];
            iss_tag   = ent_tag[i];
            iss_imm   = ent_imm[i];
            iss_data1 = ent_data1[i];
            iss_data2 = ent_data2[i];
         end
      end
   end

   for (genvar i = 0; i < NUM_RS_ENTS; i++) begin : g_ent
      rs_entry u_entry (
         .clk       (clk),
         .reset     (reset),
         .alloc     (ent_alloc[i]),
         .disp_op   (disp_op),
         .disp_tag  (disp_tag),
         .disp_imm  (disp_imm),
         .src_rdy1  (src_rdy1),
         .src_tag1  (src_tag1),
         .src_data1 (src_data1),
         .src_rdy2  (src_rdy2),
         .src_tag2  (src_tag2),
         .src_data2 (src_data2),
         .res_valid (res_valid),
         .res_tag   (res_tag),
         .res_data  (res_data),
         .grant     (ent_grant[i]),
         .valid     (ent_valid[i]),
         .req_issue (ent_req[i]),
         .ent_op    (ent_op[i]),
         .ent_tag   (ent_tag[i]),
         .ent_imm   (ent_imm[i]),
         .ent_data1 (ent_data1[i]),
         .ent_data2 (ent_data2[i])
      );
   end

endmodule

/* logic/rs_entry.sv */
`timescale 1ns/1ps

module rs_entry
   import ooo_pkg::*;
(
   input  logic    clk,
   input  logic    reset,

   input  logic    alloc,
   input  t_opcode disp_op,
   input  t_tag    disp_tag,
   input  t_imm    disp_imm,
   input  logic    src_rdy1,
   input  t_tag    src_tag1,
   input  t_data   src_data1,
   input  logic    src_rdy2,
   input  t_tag    src_tag2,
   input  t_data   src_data2,

   input  logic    res_valid,
   input  t_tag    res_tag,
   input  t_data   res_data,

   input  logic    grant,
   output logic    valid,
   output logic    req_issue,
   output t_opcode ent_op,
   output t_tag    ent_tag,
   output t_imm    ent_imm,
   output t_data   ent_data1,
   output t_data   ent_data2
);

   // Operand slots, index 0 is source 1
   logic [1:0] in_rdy;
   t_tag       in_tag   [2];
   t_data      in_data  [2];
   logic [1:0] rdy;
   t_tag       wait_tag [2];
   t_data      data     [2];

   assign in_rdy     = {src_rdy2, src_rdy1};
   assign in_tag[0]  = src_tag1;
   assign in_tag[1]  = src_tag2;
   assign in_data[0] = src_data1;
   assign in_data[1] = src_data2;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid <= 1'b0;
      end else if (alloc) begin
         valid <= 1'b1;
      end else if (grant) begin
         valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (alloc) begin
         ent_op  <= disp_op;
         ent_tag <= disp_tag;
         ent_imm <= disp_imm;
      end
      for (int s = 0; s < 2; s++) begin
         if (alloc) begin
            wait_tag[s] <= in_tag[s];
            if (in_rdy[s]) begin
               rdy[s]  <= 1'b1;
               data[s] <= in_data[s];
            end else if (res_valid && res_tag == in_tag[s]) begin
               // Broadcast on the allocation edge
               rdy[s]  <= 1'b1;
               data[s] <= res_data;
            end else begin
               rdy[s]  <= 1'b0;
            end
         end else if (valid && !rdy[s] && res_valid && res_tag == wait_tag[s]) begin
            rdy[s]  <= 1'b1;
            data[s] <= res_data;
         end
      end
   end

   assign req_issue = valid & rdy[0] & rdy[1];
   assign ent_data1 = data[0];
   assign ent_data2 = data[1];

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the issue core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f issue_core.f \
   --top-module issue_core_tb -o issue_core_sim \
&& ./obj_dir/issue_core_sim | tee sim.log \
&& grep -q "Test OK" sim.log \
&& echo "Simulation passed" \
|| { echo "Simulation failed, see sim.log"; exit 1; }

/* testbench/issue_core_checker.sv */
`timescale 1ns/1ps

module issue_core_checker
   import ooo_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     instr_valid,
   input  t_opcode  instr_op,
   input  t_reg_idx instr_rd,
   input  t_reg_idx instr_rs1,
   input  t_reg_idx instr_rs2,
   input  t_imm     instr_imm,
   input  logic     instr_stall,
   input  logic     res_valid,
   input  t_tag     res_tag,
   input  t_data    res_data,
   output int       error_count,
   output int       outstanding,
   output int       checked_count
);

   // Program-order register model
   t_data model_regs [NUM_ARCH_REGS];
   t_tag  model_tag;

   // Expected results in acceptance order
   t_tag  exp_tag_q  [$];
   t_data exp_data_q [$];

   int errs    = 0;
   int checked = 0;
   int pending = 0;

   assign error_count   = errs;
   assign checked_count = checked;
   assign outstanding   = pending;

   // Executes one instruction on the model and returns its result
   function automatic t_data apply_instr(input t_opcode op, input t_reg_idx rd,
                                         input t_reg_idx rs1, input t_reg_idx rs2,
                                         input t_imm imm);
      t_data a;
      t_data b;
      t_data r;
      a = model_regs[rs1];
      b = model_regs[rs2];
      case (op)
         OP_ADD:  r = a + b;
         OP_SUB:  r = a - b;
         OP_XOR:  r = a ^ b;
         OP_LDI:  r = {16'h0000, imm};
         default: r = '0;
      endcase
      model_regs[rd] = r;
      return r;
   endfunction

   always @(posedge clk) begin
      int idx;
      if (reset) begin
         for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            model_regs[i] = '0;
         end
         model_tag = '0;
         exp_tag_q.delete();
         exp_data_q.delete();
      end else begin
         if (res_valid) begin
            idx = -1;
            // Oldest outstanding entry with this tag
            for (int i = 0; i < exp_tag_q.size(); i++) begin
               if (idx < 0 && exp_tag_q[i] == res_tag) begin
                  idx = i;
               end
            end
            if (idx < 0) begin
               $display("Unexpected result at %0t: tag %0d has no outstanding instruction",
                        $time, res_tag);
               errs++;
            end else begin
               if (res_data !== exp_data_q[idx]) begin
                  $display("FAIL %0t: tag %0d returned %h, expected %h",
                           $time, res_tag, res_data, exp_data_q[idx]);
                  errs++;
               end
               checked++;
               exp_tag_q.delete(idx);
               exp_data_q.delete(idx);
            end
         end
         if (instr_valid && !instr_stall) begin
            exp_data_q.push_back(apply_instr(instr_op, instr_rd, instr_rs1, instr_rs2,
                                             instr_imm));
            exp_tag_q.push_back(model_tag);
            model_tag = model_tag + t_tag'(1);
         end
      end
      pending = exp_tag_q.size();
   end

endmodule

/* testbench/issue_core_props.sv */
`timescale 1ns/1ps

module issue_core_props #(
   parameter int NUM_ENTS    = 8,
   parameter bit HAS_STATION = 1'b1
) (
   input logic                clk,
   input logic                reset,
   input logic                iss_valid,
   input logic                res_valid,
   input logic [NUM_ENTS-1:0] grant,
   input logic [NUM_ENTS-1:0] ent_valid
);

   if (HAS_STATION) begin : g_station
      // Single issue per cycle
      grant_onehot: assert property (@(posedge clk) disable iff (reset)
         iss_valid |-> $onehot(grant))
         else $error("station grant is not one-hot: %b", grant);

      issue_from_valid: assert property (@(posedge clk) disable iff (reset)
         iss_valid |-> (grant & ent_valid) != '0)
         else $error("issue from an entry that holds no instruction");
   end else begin : g_alu
      // One-stage ALU
      result_latency: assert property (@(posedge clk) disable iff (reset)
         res_valid == $past(iss_valid))
         else $error("res_valid did not follow iss_valid by one cycle");
   end

endmodule

bind rs issue_core_props #(
   .NUM_ENTS    (NUM_RS_ENTS),
   .HAS_STATION (1'b1)
) u_station_props (
   .clk       (clk),
   .reset     (reset),
   .iss_valid (iss_valid),
   .res_valid (res_valid),
   .grant     (ent_grant),
   .ent_valid (ent_valid)
);

bind alu_exec issue_core_props #(
   .NUM_ENTS    (1),
   .HAS_STATION (1'b0)
) u_alu_props (
   .clk       (clk),
   .reset     (reset),
   .iss_valid (iss_valid),
   .res_valid (res_valid),
   .grant     (1'b0),
   .ent_valid (1'b0)
);

/* testbench/issue_core_tb.sv */
`timescale 1ns/1ps

module issue_core_tb
   import ooo_pkg::*;
();

   localparam int MAX_WAIT = 300;

   logic     clk;
   logic     reset;
   logic     instr_valid;
   t_opcode  instr_op;
   t_reg_idx instr_rd;
   t_reg_idx instr_rs1;
   t_reg_idx instr_rs2;
   t_imm     instr_imm;
   logic     instr_stall;
   logic     res_valid;
   t_tag     res_tag;
   t_data    res_data;

   int          check_errors;
   int          outstanding;
   int          checked_count;
   int          tb_errors;
   bit          stall_seen;

   initial clk = 1'b0;
   always #2 clk = ~clk;

   issue_core UUT (
      .clk         (clk),
      .reset       (reset),
      .instr_valid (instr_valid),
      .instr_op    (instr_op),
      .instr_rd    (instr_rd),
      .instr_rs1   (instr_rs1),
      .instr_rs2   (instr_rs2),
      .instr_imm   (instr_imm),
      .instr_stall (instr_stall),
      .res_valid   (res_valid),
      .res_tag     (res_tag),
      .res_data    (res_data)
   );

   issue_core_checker u_checker (
      .clk           (clk),
      .reset         (reset),
      .instr_valid   (instr_valid),
      .instr_op      (instr_op),
      .instr_rd      (instr_rd),
      .instr_rs1     (instr_rs1),
      .instr_rs2     (instr_rs2),
      .instr_imm     (instr_imm),
      .instr_stall   (instr_stall),
      .res_valid     (res_valid),
      .res_tag       (res_tag),
      .res_data      (res_data),
      .error_count   (check_errors),
      .outstanding   (outstanding),
      .checked_count (checked_count)
   );

   // Present one instruction, hold it until accepted, then idle for gap cycles
   task automatic send_instr(input t_opcode op, input t_reg_idx rd, input t_reg_idx rs1,
                             input t_reg_idx rs2, input t_imm imm, input int gap);
      int waited;
      waited      = 0;
      instr_valid = 1'b1;
      instr_op    = op;
      instr_rd    = rd;
      instr_rs1   = rs1;
      instr_rs2   = rs2;
      instr_imm   = imm;
      // Stall only moves after a rising edge, so it is stable here
      while (instr_stall && waited < MAX_WAIT) begin
         stall_seen = 1'b1;
         @(negedge clk);
         waited++;
      end
      if (instr_stall) begin
         $display("Timeout at %0t: instr_stall stayed high for %0d cycles", $time, waited);
         tb_errors++;
      end
      @(negedge clk);
      instr_valid = 1'b0;
      repeat (gap) @(negedge clk);
   endtask

   // Wait until every accepted instruction has broadcast its result
   task automatic drain_results(input string phase);
      int waited;
      waited = 0;
      while (outstanding != 0 && waited < MAX_WAIT) begin
         @(negedge clk);
         waited++;
      end
      if (outstanding != 0) begin
         $display("Timeout at %0t: %0d results never returned in %s", $time, outstanding, phase);
         tb_errors++;
      end
   endtask

   initial begin
      void'($urandom(32'h51fb4b6a));
      tb_errors   = 0;
      stall_seen  = 1'b0;
      reset       = 1'b1;
      instr_valid = 1'b0;
      instr_op    = OP_ADD;
      instr_rd    = '0;
      instr_rs1   = '0;
      instr_rs2   = '0;
      instr_imm   = '0;
      repeat (10) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      // Independent loads
      for (int r = 0; r < NUM_ARCH_REGS; r++) begin
         send_instr(OP_LDI, t_reg_idx'(r), '0, '0, t_imm'($urandom), 0);
      end
      drain_results("independent loads");

      // Dependent chain through r1..r3
      send_instr(OP_LDI, 3'd1, 3'd0, 3'd0, 16'h1234, 0);
      send_instr(OP_LDI, 3'd2, 3'd0, 3'd0, 16'hff01, 0);
      send_instr(OP_ADD, 3'd3, 3'd1, 3'd2, 16'h0000, 0);
      send_instr(OP_SUB, 3'd3, 3'd3, 3'd1, 16'h0000, 0);
      send_instr(OP_XOR, 3'd1, 3'd3, 3'd2, 16'h0000, 0);
      send_instr(OP_ADD, 3'd2, 3'd1, 3'd3, 16'h0000, 0);
      send_instr(OP_SUB, 3'd1, 3'd2, 3'd1, 16'h0000, 0);
      send_instr(OP_XOR, 3'd3, 3'd3, 3'd1, 16'h0000, 0);
      drain_results("dependent chain");

      // Long chain on r0 with many waiters behind it
      stall_seen = 1'b0;
      send_instr(OP_LDI, 3'd0, 3'd0, 3'd0, 16'h0003, 0);
      for (int k = 0; k < 6; k++) begin
         send_instr(OP_ADD, 3'd0, 3'd0, 3'd0, 16'h0000, 0);
      end
      for (int k = 0; k < 16; k++) begin
         send_instr(OP_XOR, t_reg_idx'(1 + k % 7), 3'd0, t_reg_idx'(1 + k % 7), '0, 0);
      end
      if (!stall_seen) begin
         $display("Station never filled: instr_stall did not rise during the long chain");
         tb_errors++;
      end
      drain_results("station fill");

      // Dependent pairs spaced so rename meets the broadcast
      for (int g = 0; g < 4; g++) begin
         send_instr(OP_LDI, 3'd4, 3'd0, 3'd0, t_imm'($urandom), g);
         send_instr(OP_ADD, 3'd5, 3'd4, 3'd4, 16'h0000, g);
         send_instr(OP_XOR, 3'd6, 3'd5, 3'd4, 16'h0000, g);
         send_instr(OP_SUB, 3'd4, 3'd6, 3'd5, 16'h0000, g);
         drain_results("bypass pairs");
      end

      // Random mixed program
      for (int n = 0; n < 300; n++) begin
         send_instr(t_opcode'($urandom_range(3, 0)), t_reg_idx'($urandom_range(7, 0)),
                    t_reg_idx'($urandom_range(7, 0)), t_reg_idx'($urandom_range(7, 0)),
                    t_imm'($urandom), $urandom_range(3, 0) == 0 ? 2 : 0);
      end
      drain_results("random program");

      $display("Done: %0d results checked, %0d check errors, %0d testbench errors",
               checked_count, check_errors, tb_errors);
      if (check_errors == 0 && tb_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule
